// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_unit_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== project.f ====
+incdir+rtl
rtl/lsu_pkg.sv
rtl/mem_bus_pkg.sv
rtl/lsu_issue_ctrl.sv
rtl/lsu_pending_counter.sv
rtl/lsu_req_format.sv
rtl/lsu_rsp_format.sv
rtl/lsu_commit_buffer.sv
rtl/lsu_commit_arb.sv
rtl/lsu_unit.sv
testbench/lsu_mem_model.sv
testbench/lsu_unit_tb.sv

// ==== rtl/lsu_commit_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_commit_arb import lsu_pkg::*; (
    input  wire             clk,
    input  wire             reset,
    input  wire             ld_valid,
    input  wire ld_commit_t ld_data,
    output logic            ld_ready,
    input  wire             st_valid,
    input  wire st_commit_t st_data,
    output logic            st_ready,
    output logic            commit_valid,
    output lsu_commit_t     commit,
    input  wire             commit_ready
);
    logic prio_ld;
    logic load_en;
    logic grant_ld;
    logic grant_st;

    // output register empty or draining
    assign load_en  = !commit_valid || commit_ready;
    assign grant_ld = ld_valid && (prio_ld || !st_valid);
    assign grant_st = st_valid && !grant_ld;
    assign ld_ready = load_en && grant_ld;
    assign st_ready = load_en && grant_st;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            prio_ld      <= 1'b1;
        end else begin
            if (load_en) commit_valid <= ld_valid || st_valid;
            // flip priority after each grant
            if (ld_ready) begin
                prio_ld <= 1'b0;
            end else if (st_ready) begin
                prio_ld <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_ready) begin
            commit.wid   <= ld_data.wid;
            commit.tmask <= ld_data.tmask;
            commit.pc    <= ld_data.pc;
            commit.rd    <= ld_data.rd;
            commit.wb    <= 1'b1;
            commit.data  <= ld_data.data;
        end else if (st_ready) begin
            commit.wid   <= st_data.wid;
            commit.tmask <= st_data.tmask;
            commit.pc    <= st_data.pc;
            commit.rd    <= '0;
            commit.wb    <= 1'b0;
            commit.data  <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lsu_commit_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_commit_buffer #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           reset,
    input  wire           in_valid,
    input  wire payload_t in_data,
    output logic          in_ready,
    output logic          out_valid,
    output payload_t      out_data,
    input  wire           out_ready
);
    payload_t   entry [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic       push;
    logic       pop;

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign in_ready  = (count != 2'd2);
    assign out_valid = (count != 2'd0);
    assign out_data  = entry[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            count  <= 2'd0;
        end else begin
            if (push) wr_ptr <= !wr_ptr;
            if (pop) rd_ptr <= !rd_ptr;
            count <= count + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) entry[wr_ptr] <= in_data;
    end

    a_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out_data))
        else $error("buffer output changed while stalled");

endmodule

`default_nettype wire

// ==== rtl/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// lanes per warp instruction
`define LSU_NUM_LANES   4

// data and address width
`define LSU_XLEN        32

// bytes in one memory word
`define LSU_WORD_BYTES  4

`define LSU_NUM_WARPS   4

`define LSU_NUM_REGS    32

// loads in flight before issue stalls
`define LSU_MAX_PENDING 8

`endif

// ==== rtl/lsu_issue_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_issue_ctrl import lsu_pkg::*; (
    input  wire          clk,
    input  wire          reset,
    input  wire          exec_valid,
    input  wire lsu_op_t exec_op,
    input  wire          pending_empty,
    input  wire          pending_full,
    input  wire          mem_req_ready,
    input  wire          st_ready,
    output logic         exec_ready,
    output logic         mem_req_valid,
    output logic         load_issue,
    output logic         st_push
);
    typedef enum logic {RUN, FENCE_WAIT} state_t;

    state_t state;
    logic   is_fence;
    logic   is_store;
    logic   slot_ok;
    logic   exec_fire;

    assign is_fence = (exec_op == FENCE);
    assign is_store = op_is_store(exec_op);
    // stores need a commit slot, loads a pending slot
    assign slot_ok  = is_store ? st_ready : !pending_full;

    assign mem_req_valid = exec_valid && !is_fence && slot_ok;
    assign exec_ready    = is_fence ? (pending_empty && st_ready)
                                    : (state == RUN && mem_req_ready && slot_ok);
    assign exec_fire     = exec_valid && exec_ready;
    assign load_issue    = exec_fire && !is_fence && !is_store;
    assign st_push       = exec_fire && (is_store || is_fence);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RUN;
        end else begin
            case (state)
                RUN:        if (exec_valid && is_fence && !pending_empty) state <= FENCE_WAIT;
                FENCE_WAIT: if (exec_fire) state <= RUN;
                default:    state <= RUN;
            endcase
        end
    end

    // upstream must keep the fence in place while it drains
    a_fence_quiet: assert property (@(posedge clk) disable iff (reset)
        state == FENCE_WAIT |-> !mem_req_valid)
        else $error("memory request raised while waiting on fence");

endmodule

`default_nettype wire

// ==== rtl/lsu_pending_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_pending_counter (
    input  wire  clk,
    input  wire  reset,
    input  wire  load_issue,
    input  wire  rsp_fire,
    output logic pending_empty,
    output logic pending_full
);
    typedef logic [$clog2(`LSU_MAX_PENDING+1)-1:0] count_t;

    count_t count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else if (load_issue && !rsp_fire) begin
            count <= count + 1'b1;
        end else if (rsp_fire && !load_issue) begin
            count <= count - 1'b1;
        end
    end

    assign pending_empty = (count == '0);
    assign pending_full  = (count == count_t'(`LSU_MAX_PENDING));

    a_no_underflow: assert property (@(posedge clk) disable iff (reset)
        rsp_fire |-> !pending_empty)
        else $error("load response with no load outstanding");
    a_no_overflow: assert property (@(posedge clk) disable iff (reset)
        load_issue |-> !pending_full)
        else $error("load issued past the outstanding limit");

endmodule

`default_nettype wire

// ==== rtl/lsu_pkg.sv ====
`default_nettype none

`include "lsu_consts.svh"

package lsu_pkg;

    typedef logic [`LSU_XLEN-1:0]               lane_word_t;
    typedef logic [`LSU_NUM_LANES-1:0]          lane_mask_t;
    typedef logic [$clog2(`LSU_NUM_WARPS)-1:0]  wid_t;
    typedef logic [$clog2(`LSU_NUM_REGS)-1:0]   reg_id_t;

    // bit 3 set for stores and fence
    typedef enum logic [3:0] {
        LB    = 4'h0,
        LH    = 4'h1,
        LW    = 4'h2,
        LBU   = 4'h4,
        LHU   = 4'h5,
        SB    = 4'h8,
        SH    = 4'h9,
        SW    = 4'ha,
        FENCE = 4'hf
    } lsu_op_t;

    typedef struct packed {
        wid_t                            wid;
        lane_mask_t                      tmask;
        lane_word_t                      pc;
        reg_id_t                         rd;
        lsu_op_t                         op;
        lane_word_t                      imm;
        lane_word_t [`LSU_NUM_LANES-1:0] rs1;
        lane_word_t [`LSU_NUM_LANES-1:0] rs2;
    } lsu_exec_t;

    typedef struct packed {
        wid_t                            wid;
        lane_mask_t                      tmask;
        lane_word_t                      pc;
        reg_id_t                         rd;
        lane_word_t [`LSU_NUM_LANES-1:0] data;
    } ld_commit_t;

    typedef struct packed {
        wid_t       wid;
        lane_mask_t tmask;
        lane_word_t pc;
    } st_commit_t;

    typedef struct packed {
        wid_t                            wid;
        lane_mask_t                      tmask;
        lane_word_t                      pc;
        reg_id_t                         rd;
        logic                            wb;
        lane_word_t [`LSU_NUM_LANES-1:0] data;
    } lsu_commit_t;

    function automatic logic op_is_store(lsu_op_t op);
        return op inside {SB, SH, SW};
    endfunction

endpackage

`default_nettype wire

// ==== rtl/lsu_req_format.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_req_format import lsu_pkg::*, mem_bus_pkg::*; (
    input  wire            clk,
    input  wire lsu_exec_t exec_data,
    input  wire            exec_fire,
    output mem_req_t       mem_req
);
    lane_word_t [`LSU_NUM_LANES-1:0] full_addr;
    align_t [`LSU_NUM_LANES-1:0]     req_align;
    logic                            half_op;
    logic                            word_op;

    assign half_op = exec_data.op inside {LH, LHU, SH};
    assign word_op = exec_data.op inside {LW, SW};

    always_comb begin
        mem_req.rw   = op_is_store(exec_data.op);
        mem_req.mask = exec_data.tmask;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            full_addr[i]      = exec_data.rs1[i] + exec_data.imm;
            req_align[i]      = full_addr[i][$bits(align_t)-1:0];
            mem_req.addr[i]   = full_addr[i][`LSU_XLEN-1:$bits(align_t)];
            case (exec_data.op)
                SB:      mem_req.byteen[i] = byteen_t'(1) << req_align[i];
                SH:      mem_req.byteen[i] = byteen_t'(2'b11) << {req_align[i][1], 1'b0};
                default: mem_req.byteen[i] = '1;
            endcase
            // byte lane shift of store data
            mem_req.data[i] = exec_data.rs2[i] << {req_align[i], 3'b000};
        end
        mem_req.tag.wid   = exec_data.wid;
        mem_req.tag.tmask = exec_data.tmask;
        mem_req.tag.pc    = exec_data.pc;
        mem_req.tag.rd    = exec_data.rd;
        mem_req.tag.op    = exec_data.op;
        mem_req.tag.align = req_align;
    end

    // no misaligned accesses on active lanes
    for (genvar i = 0; i < `LSU_NUM_LANES; i++) begin : g_align_chk
        a_aligned: assert property (@(posedge clk)
            exec_fire && exec_data.tmask[i]
                |-> !(half_op && req_align[i][0]) && !(word_op && req_align[i] != '0))
            else $error("misaligned access on lane %0d, pc=0x%0h", i, exec_data.pc);
    end

endmodule

`default_nettype wire

// ==== rtl/lsu_rsp_format.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_rsp_format import lsu_pkg::*, mem_bus_pkg::*; (
    input  wire mem_rsp_t mem_rsp,
    output ld_commit_t    ld_data
);
    logic [`LSU_NUM_LANES-1:0][15:0] rsp_half;
    logic [`LSU_NUM_LANES-1:0][7:0]  rsp_byte;

    always_comb begin
        ld_data.wid   = mem_rsp.tag.wid;
        ld_data.tmask = mem_rsp.mask;
        ld_data.pc    = mem_rsp.tag.pc;
        ld_data.rd    = mem_rsp.tag.rd;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            // halfword first, then byte within it
            rsp_half[i] = mem_rsp.tag.align[i][1] ? mem_rsp.data[i][31:16]
                                                  : mem_rsp.data[i][15:0];
            rsp_byte[i] = mem_rsp.tag.align[i][0] ? rsp_half[i][15:8] : rsp_half[i][7:0];
            case (mem_rsp.tag.op)
                LB:      ld_data.data[i] = lane_word_t'(signed'(rsp_byte[i]));
                LH:      ld_data.data[i] = lane_word_t'(signed'(rsp_half[i]));
                LBU:     ld_data.data[i] = lane_word_t'(rsp_byte[i]);
                LHU:     ld_data.data[i] = lane_word_t'(rsp_half[i]);
                default: ld_data.data[i] = mem_rsp.data[i];
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/lsu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module lsu_unit import lsu_pkg::*, mem_bus_pkg::*; (
    input  wire            clk,
    input  wire            reset,
    input  wire            exec_valid,
    input  wire lsu_exec_t exec_data,
    output logic           exec_ready,
    output logic           mem_req_valid,
    output mem_req_t       mem_req,
    input  wire            mem_req_ready,
    input  wire            mem_rsp_valid,
    input  wire mem_rsp_t  mem_rsp,
    output logic           mem_rsp_ready,
    output logic           commit_valid,
    output lsu_commit_t    commit,
    input  wire            commit_ready
);
    logic       pending_empty;
    logic       pending_full;
    logic       load_issue;
    logic       st_push;
    logic       st_buf_ready;
    logic       exec_fire;
    logic       rsp_fire;
    ld_commit_t ld_rsp;
    ld_commit_t ld_out;
    logic       ld_valid;
    logic       ld_ready;
    st_commit_t st_in;
    st_commit_t st_out;
    logic       st_valid;
    logic       st_ready;

    assign exec_fire   = exec_valid && exec_ready;
    assign rsp_fire    = mem_rsp_valid && mem_rsp_ready;
    assign st_in.wid   = exec_data.wid;
    assign st_in.tmask = exec_data.tmask;
    assign st_in.pc    = exec_data.pc;

    lsu_issue_ctrl issue_ctrl (
        .clk           (clk),
        .reset         (reset),
        .exec_valid    (exec_valid),
        .exec_op       (exec_data.op),
        .pending_empty (pending_empty),
        .pending_full  (pending_full),
        .mem_req_ready (mem_req_ready),
        .st_ready      (st_buf_ready),
        .exec_ready    (exec_ready),
        .mem_req_valid (mem_req_valid),
        .load_issue    (load_issue),
        .st_push       (st_push)
    );

    lsu_pending_counter pending_ctr (
        .clk           (clk),
        .reset         (reset),
        .load_issue    (load_issue),
        .rsp_fire      (rsp_fire),
        .pending_empty (pending_empty),
        .pending_full  (pending_full)
    );

    lsu_req_format req_fmt (
        .clk       (clk),
        .exec_data (exec_data),
        .exec_fire (exec_fire),
        .mem_req   (mem_req)
    );

    lsu_rsp_format rsp_fmt (
        .mem_rsp (mem_rsp),
        .ld_data (ld_rsp)
    );

    lsu_commit_buffer #(.payload_t(ld_commit_t)) ld_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (mem_rsp_valid),
        .in_data   (ld_rsp),
        .in_ready  (mem_rsp_ready),
        .out_valid (ld_valid),
        .out_data  (ld_out),
        .out_ready (ld_ready)
    );

    lsu_commit_buffer #(.payload_t(st_commit_t)) st_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (st_push),
        .in_data   (st_in),
        .in_ready  (st_buf_ready),
        .out_valid (st_valid),
        .out_data  (st_out),
        .out_ready (st_ready)
    );

    lsu_commit_arb commit_arb (
        .clk          (clk),
        .reset        (reset),
        .ld_valid     (ld_valid),
        .ld_data      (ld_out),
        .ld_ready     (ld_ready),
        .st_valid     (st_valid),
        .st_data      (st_out),
        .st_ready     (st_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

`default_nettype wire

// ==== rtl/mem_bus_pkg.sv ====
`default_nettype none

`include "lsu_consts.svh"

package mem_bus_pkg;
    import lsu_pkg::*;

    typedef logic [$clog2(`LSU_WORD_BYTES)-1:0]           align_t;
    typedef logic [`LSU_XLEN-$clog2(`LSU_WORD_BYTES)-1:0] word_addr_t;
    typedef logic [`LSU_WORD_BYTES-1:0]                   byteen_t;

    // everything a load response needs to be committed
    typedef struct packed {
        wid_t                         wid;
        lane_mask_t                   tmask;
        lane_word_t                   pc;
        reg_id_t                      rd;
        lsu_op_t                      op;
        align_t [`LSU_NUM_LANES-1:0]  align;
    } mem_tag_t;

    typedef struct packed {
        logic                            rw;
        lane_mask_t                      mask;
        word_addr_t [`LSU_NUM_LANES-1:0] addr;
        byteen_t [`LSU_NUM_LANES-1:0]    byteen;
        lane_word_t [`LSU_NUM_LANES-1:0] data;
        mem_tag_t                        tag;
    } mem_req_t;

    typedef struct packed {
        lane_mask_t                      mask;
        lane_word_t [`LSU_NUM_LANES-1:0] data;
        mem_tag_t                        tag;
    } mem_rsp_t;

endpackage

`default_nettype wire

// ==== testbench/lsu_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_mem_model import lsu_pkg::*, mem_bus_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire           mem_req_valid,
    input  wire mem_req_t mem_req,
    output logic          mem_req_ready,
    output logic          mem_rsp_valid,
    output mem_rsp_t      mem_rsp,
    input  wire           mem_rsp_ready,
    output logic [3:0]    held_count
);
    lane_word_t mem [word_addr_t];
    mem_rsp_t   slot_rsp  [`LSU_MAX_PENDING];
    int         slot_wait [`LSU_MAX_PENDING];
    logic       slot_used [`LSU_MAX_PENDING];
    int         cur;
    logic [31:0] rng;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // initial contents depend on every address bit
    function automatic lane_word_t fill_word(word_addr_t a);
        return ({a, 2'b00} * 32'h9e37_79b1) ^ 32'h6c07_8965;
    endfunction

    function automatic lane_word_t read_word(word_addr_t a);
        return mem.exists(a) ? mem[a] : fill_word(a);
    endfunction

    initial begin
        logic       req_fire;
        logic       rsp_fire;
        logic       rst;
        mem_req_t   req;
        lane_word_t w;
        int         j;
        int         n;
        mem_req_ready = 1'b1;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        held_count    = '0;
        cur           = -1;
        rng           = 32'd75;
        foreach (slot_used[k]) slot_used[k] = 1'b0;
        forever begin
            @(posedge clk);
            rst      = reset;
            req_fire = mem_req_valid && mem_req_ready;
            rsp_fire = mem_rsp_valid && mem_rsp_ready;
            req      = mem_req;
            #5;
            if (rst) begin
                foreach (slot_used[k]) slot_used[k] = 1'b0;
                cur           = -1;
                mem_rsp_valid = 1'b0;
            end else begin
                if (rsp_fire) begin
                    slot_used[cur] = 1'b0;
                    cur            = -1;
                    mem_rsp_valid  = 1'b0;
                end
                foreach (slot_used[k]) begin
                    if (slot_used[k] && slot_wait[k] > 0) slot_wait[k]--;
                end
                if (req_fire && req.rw) begin
                    for (int i = 0; i < `LSU_NUM_LANES; i++) begin
                        if (req.mask[i]) begin
                            w = read_word(req.addr[i]);
                            for (int b = 0; b < 4; b++) begin
                                if (req.byteen[i][b]) w[8*b +: 8] = req.data[i][8*b +: 8];
                            end
                            mem[req.addr[i]] = w;
                        end
                    end
                end else if (req_fire) begin
                    j = 0;
                    while (slot_used[j]) j++;
                    rng = lcg_step(rng);
                    slot_used[j]          = 1'b1;
                    slot_wait[j]          = int'(rng[18:16]);
                    slot_rsp[j].mask      = req.mask;
                    slot_rsp[j].tag       = req.tag;
                    for (int i = 0; i < `LSU_NUM_LANES; i++) begin
                        slot_rsp[j].data[i] = read_word(req.addr[i]);
                    end
                end
                // ready slots answer from a random start, so order is lost
                if (cur < 0) begin
                    rng = lcg_step(rng);
                    for (int k = 0; k < `LSU_MAX_PENDING; k++) begin
                        j = (int'(rng[18:16]) + k) % `LSU_MAX_PENDING;
                        if (cur < 0 && slot_used[j] && slot_wait[j] == 0) cur = j;
                    end
                    if (cur >= 0) begin
                        mem_rsp       = slot_rsp[cur];
                        mem_rsp_valid = 1'b1;
                    end
                end
            end
            n = 0;
            foreach (slot_used[k]) n += int'(slot_used[k]);
            held_count = 4'(n);
        end
    end

endmodule

`default_nettype wire

// ==== testbench/lsu_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lsu_consts.svh"

module lsu_unit_tb import lsu_pkg::*, mem_bus_pkg::*; ();
    logic        clk;
    logic        reset;
    logic        exec_valid;
    lsu_exec_t   exec_data;
    logic        exec_ready;
    logic        mem_req_valid;
    mem_req_t    mem_req;
    logic        mem_req_ready;
    logic        mem_rsp_valid;
    mem_rsp_t    mem_rsp;
    logic        mem_rsp_ready;
    logic        commit_valid;
    lsu_commit_t commit;
    logic        commit_ready;
    logic [3:0]  held_count;
    lsu_commit_t expect_q [$];
    lane_word_t  shadow [logic [29:0]];
    logic [31:0] seed_st;
    logic [31:0] stall_st;
    logic [31:0] pc_next;

    lsu_unit lsu_unit_inst (.*);

    lsu_mem_model mem_model (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        seed_st = lcg_step(seed_st);
        return seed_st;
    endfunction

    function automatic lane_word_t shadow_read(logic [29:0] a);
        return shadow.exists(a) ? shadow[a] : (({a, 2'b00} * 32'h9e37_79b1) ^ 32'h6c07_8965);
    endfunction

    function automatic logic [1:0] legal_align(lsu_op_t op, logic [1:0] r);
        case (op)
            SB, LB, LBU: return r;
            SH, LH, LHU: return {r[1], 1'b0};
            default:     return 2'b00;
        endcase
    endfunction

    function automatic lane_word_t load_extend(lsu_op_t op, lane_word_t v);
        case (op)
            LB:      return {{24{v[7]}}, v[7:0]};
            LH:      return {{16{v[15]}}, v[15:0]};
            LBU:     return {24'h0, v[7:0]};
            LHU:     return {16'h0, v[15:0]};
            default: return v;
        endcase
    endfunction

    task automatic report_text(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("error %s: got 0x%08h, expected 0x%08h", name, got, exp);
            report_text("value mismatch");
        end
    endtask

    task automatic check_request(input lsu_exec_t ex);
        logic [31:0] full;
        logic [3:0]  be;
        check_value("mem_req_valid", 32'(mem_req_valid), 32'd1);
        check_value("mem_req.rw", 32'(mem_req.rw), 32'(ex.op inside {SB, SH, SW}));
        check_value("mem_req.mask", 32'(mem_req.mask), 32'(ex.tmask));
        check_value("mem_req.tag.wid", 32'(mem_req.tag.wid), 32'(ex.wid));
        check_value("mem_req.tag.tmask", 32'(mem_req.tag.tmask), 32'(ex.tmask));
        check_value("mem_req.tag.pc", mem_req.tag.pc, ex.pc);
        check_value("mem_req.tag.rd", 32'(mem_req.tag.rd), 32'(ex.rd));
        check_value("mem_req.tag.op", 32'(mem_req.tag.op), 32'(ex.op));
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            full = ex.rs1[i] + ex.imm;
            be   = (ex.op == SB) ? 4'b0001 << full[1:0]
                 : (ex.op == SH) ? 4'b0011 << full[1:0] : 4'hf;
            if (ex.tmask[i]) begin
                check_value($sformatf("mem_req.addr[%0d]", i), 32'(mem_req.addr[i]),
                            32'(full[31:2]));
                check_value($sformatf("mem_req.byteen[%0d]", i), 32'(mem_req.byteen[i]), 32'(be));
                check_value($sformatf("mem_req.tag.align[%0d]", i),
                            32'(mem_req.tag.align[i]), 32'(full[1:0]));
                if (ex.op inside {SB, SH, SW}) begin
                    check_value($sformatf("mem_req.data[%0d]", i), mem_req.data[i],
                                ex.rs2[i] << (8 * full[1:0]));
                end
            end
        end
    endtask

    // fix < 0 picks random words and alignments, else word 0 at that alignment
    task automatic issue_op(input lsu_op_t op, input int fix);
        lsu_exec_t   ex;
        lsu_commit_t exp;
        logic [31:0] r;
        logic [31:0] full;
        logic [1:0]  al;
        lane_word_t  w;
        int          waited;
        logic        fired;
        r        = next_rand();
        ex       = '0;
        ex.wid   = r[17:16];
        ex.tmask = (r[21:18] == 4'h0) ? 4'b0001 : r[21:18];
        ex.pc    = pc_next;
        ex.rd    = r[26:22];
        ex.op    = op;
        ex.imm   = (r[27] && fix < 0) ? 32'h20 : 32'h0;
        pc_next  = pc_next + 32'd4;
        exp       = '0;
        exp.wid   = ex.wid;
        exp.tmask = ex.tmask;
        exp.pc    = ex.pc;
        exp.wb    = !(op inside {SB, SH, SW, FENCE});
        exp.rd    = exp.wb ? ex.rd : '0;
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            r  = next_rand();
            al = (fix < 0) ? legal_align(op, r[17:16]) : 2'(fix);
            ex.rs1[i] = 32'h1000 + 32'(i) * 32'h40 + 32'(al)
                      + ((fix < 0) ? 32'({r[22:20], 2'b00}) : 32'h0);
            ex.rs2[i] = next_rand();
            full = ex.rs1[i] + ex.imm;
            w    = shadow_read(full[31:2]);
            if (ex.tmask[i] && op inside {SB, SH, SW}) begin
                case (op)
                    SB:      w[8*full[1:0] +: 8] = ex.rs2[i][7:0];
                    SH:      w[8*full[1:0] +: 16] = ex.rs2[i][15:0];
                    default: w = ex.rs2[i];
                endcase
                shadow[full[31:2]] = w;
            end
            if (exp.wb) exp.data[i] = load_extend(op, w >> (8 * full[1:0]));
        end
        expect_q.push_back(exp);
        exec_data  = ex;
        exec_valid = 1'b1;
        waited     = 0;
        fired      = 1'b0;
        while (!fired) begin
            @(posedge clk);
            if (exec_ready) begin
                fired = 1'b1;
                if (op != FENCE) begin
                    check_request(ex);
                end else begin
                    check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);
                end
            end else begin
                waited++;
                assert (waited < 300) else report_text("execute handshake timed out");
            end
        end
        #5;
        exec_valid = 1'b0;
    endtask

    task automatic match_commit();
        int          idx;
        lsu_commit_t e;
        idx = -1;
        foreach (expect_q[k]) begin
            if (expect_q[k].pc == commit.pc && expect_q[k].wid == commit.wid) idx = k;
        end
        assert (idx >= 0) else report_text("commit with no matching instruction");
        e = expect_q[idx];
        check_value("commit.wb", 32'(commit.wb), 32'(e.wb));
        check_value("commit.tmask", 32'(commit.tmask), 32'(e.tmask));
        check_value("commit.rd", 32'(commit.rd), 32'(e.rd));
        for (int i = 0; i < `LSU_NUM_LANES; i++) begin
            if (!e.wb || e.tmask[i]) begin
                check_value($sformatf("commit.data[%0d]", i), commit.data[i], e.data[i]);
            end
        end
        expect_q.delete(idx);
    endtask

    always @(posedge clk) begin
        if (!reset && commit_valid && commit_ready) match_commit();
    end

    // random commit back-pressure
    initial begin
        commit_ready = 1'b1;
        stall_st     = 32'd75;
        forever begin
            @(posedge clk);
            #5;
            stall_st     = lcg_step(stall_st);
            commit_ready = (stall_st[17:16] != 2'b00);
        end
    end

    a_commit_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else report_text("commit changed while stalled");

    a_fence_drained: assert property (@(posedge clk) disable iff (reset)
        exec_valid && exec_ready && exec_data.op == FENCE |-> held_count == 4'd0)
        else report_text("fence accepted with load responses still held");

    initial begin
        lsu_op_t ops [9];
        int      waited;
        ops        = '{LB, LH, LW, LBU, LHU, SB, SH, SW, FENCE};
        seed_st    = 32'd75;
        pc_next    = 32'h100;
        reset      = 1'b1;
        exec_valid = 1'b0;
        exec_data  = '0;
        repeat (4) @(posedge clk);
        #5;
        reset = 1'b0;
        check_value("commit_valid", 32'(commit_valid), 32'd0);
        check_value("mem_req_valid", 32'(mem_req_valid), 32'd0);
        repeat (6) issue_op(SW, -1);
        for (int k = 0; k < 4; k++) issue_op(SB, k);
        issue_op(SH, 0);
        issue_op(SH, 2);
        issue_op(LW, 0);
        for (int k = 0; k < 30; k++) issue_op(ops[next_rand() % 5], -1);
        repeat (4) issue_op(LW, -1);
        issue_op(FENCE, -1);
        for (int k = 0; k < 60; k++) issue_op(ops[next_rand() % 9], -1);
        waited = 0;
        while (expect_q.size() != 0) begin
            @(posedge clk);
            waited++;
            assert (waited < 1000) else report_text("commits did not drain in time");
        end
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
